/* design/sdmac_macros.svh */
// Sizes, register map and CTRL bit positions of the SCSI DMA controller
// Shared by the RTL and the testbench
`ifndef SDMAC_MACROS_SVH
`define SDMAC_MACROS_SVH

// FIFO geometry, depth must be 2**AW
`define SDMAC_FIFO_DEPTH 8
`define SDMAC_FIFO_AW    3

// Data, word count and Wishbone address widths
`define SDMAC_DATA_W  32
`define SDMAC_COUNT_W 16
`define SDMAC_WB_AW   3

// Register word offsets on the Wishbone port
`define SDMAC_REG_CTRL   3'd0
`define SDMAC_REG_ADDR   3'd1
`define SDMAC_REG_COUNT  3'd2
`define SDMAC_REG_STATUS 3'd3
`define SDMAC_REG_DATA   3'd4

// CTRL register bits
`define SDMAC_CTRL_ENA   0
`define SDMAC_CTRL_DIR   1
`define SDMAC_CTRL_FLUSH 2
`endif

/* design/sdmac_pkg.sv */
// Packed structs for the DMA configuration, the status word,
// and the request, response and arbitration groups of the CPU bus
`include "sdmac_macros.svh"

package sdmac_pkg;

    // Programmed transfer, dir 1 reads the bus into the FIFO
    typedef struct packed {
        logic                      dir;
        logic                      enable;
        logic                      flush;
        logic [`SDMAC_DATA_W-1:0]  addr;
        logic [`SDMAC_COUNT_W-1:0] count;
    } dma_cfg_t;

    // STATUS register contents, busy in the top bit
    typedef struct packed {
        logic                     busy;
        logic                     done;
        logic [`SDMAC_FIFO_AW:0]  fifo_level;
    } dma_stat_t;

    // Master side of one bus cycle, strobes active low
    typedef struct packed {
        logic                     as_;
        logic                     ds_;
        logic                     rw;
        logic                     siz16;
        logic [`SDMAC_DATA_W-1:0] addr;
        logic [`SDMAC_DATA_W-1:0] wdata;
    } cpu_req_t;

    // Slave answer, dsack_ of 2'b01 marks a 16-bit port
    typedef struct packed {
        logic [1:0]               dsack_;
        logic                     sterm_;
        logic [`SDMAC_DATA_W-1:0] rdata;
    } cpu_rsp_t;

    typedef struct packed {
        logic breq;
        logic bgack;
    } bus_arb_t;

endpackage

/* design/dma_regs.sv */
// Wishbone classic slave with the CTRL, ADDR, COUNT and STATUS registers
// and the FIFO data port, plus start pulse and done flag handling
`include "sdmac_macros.svh"

module dma_regs (
    input  logic                         CLK90,
    input  logic                         CCRESET_,
    input  logic                         wb_cyc,
    input  logic                         wb_stb,
    input  logic                         wb_we,
    input  logic [`SDMAC_WB_AW-1:0]      wb_adr,
    input  logic [`SDMAC_DATA_W-1:0]     wb_dat_w,
    output logic [`SDMAC_DATA_W-1:0]     wb_dat_r,
    output logic                         wb_ack,
    output sdmac_pkg::dma_cfg_t          cfg,
    output logic                         start,
    input  logic                         busy,
    input  logic                         finish,
    input  logic                         fifo_full,
    input  logic                         fifo_empty,
    input  logic [`SDMAC_FIFO_AW:0]      fifo_level,
    input  logic [`SDMAC_DATA_W-1:0]     fifo_rdata,
    output logic                         fifo_push,
    output logic                         fifo_pop,
    output logic [`SDMAC_DATA_W-1:0]     fifo_wdata
);

    logic                     done_q;
    logic                     data_sel;
    logic                     data_ok;
    logic                     acc;
    logic                     wr;
    logic                     rd;
    logic [`SDMAC_DATA_W-1:0] rd_word;
    sdmac_pkg::dma_stat_t     stat;

    // DATA accesses wait until the FIFO can take or give a word
    assign data_sel = (wb_adr == `SDMAC_REG_DATA);
    assign data_ok  = wb_we ? ~fifo_full : ~fifo_empty;
    assign acc      = wb_cyc & wb_stb & ~wb_ack & (~data_sel | data_ok);
    assign wr       = acc & wb_we;
    assign rd       = acc & ~wb_we;

    assign fifo_push  = wr & data_sel;
    assign fifo_pop   = rd & data_sel;
    assign fifo_wdata = wb_dat_w;

    assign stat = '{busy: busy, done: done_q, fifo_level: fifo_level};

    always_comb begin
        rd_word = '0;
        case (wb_adr)
            `SDMAC_REG_CTRL: begin
                rd_word[`SDMAC_CTRL_ENA]   = cfg.enable;
                rd_word[`SDMAC_CTRL_DIR]   = cfg.dir;
                rd_word[`SDMAC_CTRL_FLUSH] = cfg.flush;
            end
            `SDMAC_REG_ADDR:   rd_word = cfg.addr;
            `SDMAC_REG_COUNT:  rd_word = `SDMAC_DATA_W'(cfg.count);
            `SDMAC_REG_STATUS: rd_word = `SDMAC_DATA_W'(stat);
            `SDMAC_REG_DATA:   rd_word = fifo_rdata;
            default:           rd_word = '0;
        endcase
    end

    always_ff @(posedge CLK90 or negedge CCRESET_) begin
        if (!CCRESET_) begin
            wb_ack <= 1'b0;
            start  <= 1'b0;
            done_q <= 1'b0;
            cfg    <= '0;
        end else begin
            wb_ack <= acc;
            start  <= 1'b0;
            if (wr) begin
                case (wb_adr)
                    `SDMAC_REG_CTRL: begin
                        // Direction and enable are frozen during a transfer
                        if (!busy) begin
                            cfg.enable <= wb_dat_w[`SDMAC_CTRL_ENA];
                            cfg.dir    <= wb_dat_w[`SDMAC_CTRL_DIR];
                        end
                        cfg.flush <= wb_dat_w[`SDMAC_CTRL_FLUSH] & busy;
                        start     <= wb_dat_w[`SDMAC_CTRL_ENA] & ~busy;
                        done_q    <= 1'b0;
                    end
                    `SDMAC_REG_ADDR:  cfg.addr  <= wb_dat_w;
                    `SDMAC_REG_COUNT: cfg.count <= wb_dat_w[`SDMAC_COUNT_W-1:0];
                    default: ;
                endcase
            end
            // End of transfer wins over a CTRL write in the same cycle
            if (finish) begin
                done_q     <= 1'b1;
                cfg.enable <= 1'b0;
                cfg.flush  <= 1'b0;
            end
        end
    end

    // Read data is captured with the acknowledge
    always_ff @(posedge CLK90) begin
        if (rd) begin
            wb_dat_r <= rd_word;
        end
    end

endmodule

/* design/dma_fifo.sv */
// Word FIFO between the Wishbone side and the CPU bus side
// Circular buffer with level counter, full and empty flags
`include "sdmac_macros.svh"

module dma_fifo (
    input  logic                     CLK90,
    input  logic                     CCRESET_,
    input  logic                     host_push,
    input  logic                     host_pop,
    input  logic [`SDMAC_DATA_W-1:0] host_wdata,
    input  logic                     bus_push,
    input  logic                     bus_pop,
    input  logic [`SDMAC_DATA_W-1:0] bus_wdata,
    output logic [`SDMAC_DATA_W-1:0] rdata,
    output logic                     full,
    output logic                     empty,
    output logic [`SDMAC_FIFO_AW:0]  level
);

    logic [`SDMAC_DATA_W-1:0]  mem [`SDMAC_FIFO_DEPTH];
    logic [`SDMAC_FIFO_AW-1:0] wr_ptr;
    logic [`SDMAC_FIFO_AW-1:0] rd_ptr;
    logic [`SDMAC_DATA_W-1:0]  wdata;
    logic                      do_push;
    logic                      do_pop;

    // Only one side pushes for a given direction
    assign wdata   = bus_push ? bus_wdata : host_wdata;
    assign do_push = (host_push | bus_push) & ~full;
    assign do_pop  = (host_pop | bus_pop) & ~empty;

    assign full  = (level == (`SDMAC_FIFO_AW+1)'(`SDMAC_FIFO_DEPTH));
    assign empty = (level == '0);
    assign rdata = mem[rd_ptr];

    always_ff @(posedge CLK90) begin
        if (do_push) begin
            mem[wr_ptr] <= wdata;
        end
    end

    // Pointers wrap on their own since the depth is a power of two
    always_ff @(posedge CLK90 or negedge CCRESET_) begin
        if (!CCRESET_) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            level  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   level <= level + 1'b1;
                2'b01:   level <= level - 1'b1;
                default: level <= level;
            endcase
        end
    end

endmodule

/* design/cpu_bus_sm.sv */
// CPU bus master FSM: arbitration, address and data strobes, acknowledge
// decode, 16-bit port word splitting, address and count advance, flush
`include "sdmac_macros.svh"

module cpu_bus_sm (
    input  logic                     CLK90,
    input  logic                     CCRESET_,
    input  sdmac_pkg::dma_cfg_t      cfg,
    input  logic                     start,
    input  logic                     bgrant_,
    input  sdmac_pkg::cpu_rsp_t      rsp,
    input  logic                     fifo_full,
    input  logic                     fifo_empty,
    input  logic [`SDMAC_DATA_W-1:0] fifo_rdata,
    output sdmac_pkg::cpu_req_t      req,
    output sdmac_pkg::bus_arb_t      arb,
    output logic                     busy,
    output logic                     finish,
    output logic                     fifo_push,
    output logic                     fifo_pop,
    output logic [`SDMAC_DATA_W-1:0] fifo_wdata
);

    typedef enum logic [2:0] {
        S_IDLE, S_REQ, S_GRANT, S_STROBE, S_WAIT, S_SECOND, S_RELEASE
    } state_t;

    state_t                    state_q;
    state_t                    state_d;
    logic                      bgrant_q;
    sdmac_pkg::cpu_rsp_t       rsp_q;
    logic [`SDMAC_DATA_W-1:0]  addr_q;
    logic [`SDMAC_COUNT_W-1:0] cnt_q;
    logic                      half_q;
    logic [15:0]               rd_hi_q;
    logic                      rsp_ack;
    logic                      port16;
    logic                      fifo_ok;
    logic                      term;
    logic                      settled;
    logic                      launch;

    // Acknowledge and port size from the registered inputs
    assign rsp_ack = (rsp_q.dsack_ != 2'b11) | ~rsp_q.sterm_;
    assign port16  = rsp_q.sterm_ & (rsp_q.dsack_ == 2'b01);

    // Room for a word on the bus side of the FIFO
    assign fifo_ok = cfg.dir ? ~fifo_full : ~fifo_empty;

    // A read flush stops after the word in flight, a write flush drains first
    assign term = (cnt_q == '0) | (cfg.flush & (cfg.dir | fifo_empty));

    // Old acknowledge gone and the last FIFO strobe taken
    assign settled = ~rsp_ack & ~fifo_push & ~fifo_pop;

    always_comb begin
        state_d = state_q;
        launch  = 1'b0;
        case (state_q)
            S_IDLE: begin
                if (start) begin
                    state_d = S_REQ;
                end
            end
            S_REQ: begin
                if (term) begin
                    state_d = S_RELEASE;
                end else if (arb.breq & fifo_ok & ~bgrant_q) begin
                    state_d = S_GRANT;
                end
            end
            S_GRANT, S_SECOND: begin
                if (!rsp_ack) begin
                    launch  = 1'b1;
                    state_d = S_WAIT;
                end
            end
            S_WAIT: begin
                if (rsp_ack) begin
                    state_d = (port16 && !half_q) ? S_SECOND : S_STROBE;
                end
            end
            S_STROBE: begin
                // Gap between words, keep the bus while the FIFO allows
                if (settled) begin
                    if (term || !fifo_ok) begin
                        state_d = S_RELEASE;
                    end else begin
                        launch  = 1'b1;
                        state_d = S_WAIT;
                    end
                end
            end
            S_RELEASE: state_d = term ? S_IDLE : S_REQ;
            default:   state_d = S_IDLE;
        endcase
    end

    always_ff @(posedge CLK90 or negedge CCRESET_) begin
        if (!CCRESET_) begin
            state_q   <= S_IDLE;
            bgrant_q  <= 1'b1;
            rsp_q     <= '{dsack_: 2'b11, sterm_: 1'b1, rdata: '0};
            req       <= '{as_: 1'b1, ds_: 1'b1, rw: 1'b1, siz16: 1'b0, addr: '0, wdata: '0};
            arb       <= '0;
            busy      <= 1'b0;
            finish    <= 1'b0;
            fifo_push <= 1'b0;
            fifo_pop  <= 1'b0;
            addr_q    <= '0;
            cnt_q     <= '0;
            half_q    <= 1'b0;
        end else begin
            state_q   <= state_d;
            bgrant_q  <= bgrant_;
            rsp_q     <= rsp;
            arb.breq  <= (state_d == S_REQ) & fifo_ok & ~term;
            arb.bgack <= state_d inside {S_GRANT, S_STROBE, S_WAIT, S_SECOND};
            finish    <= 1'b0;
            fifo_push <= 1'b0;
            fifo_pop  <= 1'b0;

            if (state_q == S_IDLE && start) begin
                busy   <= 1'b1;
                addr_q <= cfg.addr;
                cnt_q  <= cfg.count;
                half_q <= 1'b0;
            end
            if (state_q == S_RELEASE && term) begin
                busy   <= 1'b0;
                finish <= 1'b1;
            end

            // Start a cycle, the low half goes to addr+2 on D31:16
            if (launch) begin
                req.as_   <= 1'b0;
                req.ds_   <= 1'b0;
                req.rw    <= cfg.dir;
                req.siz16 <= half_q;
                req.addr  <= half_q ? addr_q + 2 : addr_q;
                if (!cfg.dir) begin
                    req.wdata <= half_q ? {2{req.wdata[15:0]}} : fifo_rdata;
                    fifo_pop  <= ~half_q;
                end
            end

            if (state_q == S_WAIT && rsp_ack) begin
                req.as_ <= 1'b1;
                req.ds_ <= 1'b1;
                if (port16 && !half_q) begin
                    half_q <= 1'b1;
                end else begin
                    half_q    <= 1'b0;
                    addr_q    <= addr_q + 4;
                    cnt_q     <= cnt_q - 1'b1;
                    fifo_push <= cfg.dir;
                end
            end
        end
    end

    // Read halves are assembled high first, a 16-bit port answers on D31:16
    always_ff @(posedge CLK90) begin
        if (state_q == S_WAIT && rsp_ack) begin
            if (port16 && !half_q) begin
                rd_hi_q <= rsp_q.rdata[31:16];
            end else begin
                fifo_wdata <= half_q ? {rd_hi_q, rsp_q.rdata[31:16]} : rsp_q.rdata;
            end
        end
    end

endmodule

/* design/sdmac_top.sv */
// SCSI DMA controller top level
// Register block, word FIFO and CPU bus master
`include "sdmac_macros.svh"

module sdmac_top (
    input  logic                     CLK90,
    input  logic                     CCRESET_,
    input  logic                     wb_cyc,
    input  logic                     wb_stb,
    input  logic                     wb_we,
    input  logic [`SDMAC_WB_AW-1:0]  wb_adr,
    input  logic [`SDMAC_DATA_W-1:0] wb_dat_w,
    output logic [`SDMAC_DATA_W-1:0] wb_dat_r,
    output logic                     wb_ack,
    input  logic                     bgrant_,
    input  sdmac_pkg::cpu_rsp_t      rsp,
    output sdmac_pkg::cpu_req_t      req,
    output sdmac_pkg::bus_arb_t      arb
);

    sdmac_pkg::dma_cfg_t      cfg;
    logic                     start;
    logic                     busy;
    logic                     finish;
    logic                     host_push;
    logic                     host_pop;
    logic [`SDMAC_DATA_W-1:0] host_wdata;
    logic                     bus_push;
    logic                     bus_pop;
    logic [`SDMAC_DATA_W-1:0] bus_wdata;
    logic [`SDMAC_DATA_W-1:0] fifo_rdata;
    logic                     fifo_full;
    logic                     fifo_empty;
    logic [`SDMAC_FIFO_AW:0]  fifo_level;

    dma_regs u_regs (
        .CLK90, .CCRESET_,
        .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w, .wb_dat_r, .wb_ack,
        .cfg, .start, .busy, .finish,
        .fifo_full, .fifo_empty, .fifo_level, .fifo_rdata,
        .fifo_push  (host_push),
        .fifo_pop   (host_pop),
        .fifo_wdata (host_wdata)
    );

    dma_fifo u_fifo (
        .CLK90, .CCRESET_,
        .host_push, .host_pop, .host_wdata,
        .bus_push, .bus_pop, .bus_wdata,
        .rdata (fifo_rdata),
        .full  (fifo_full),
        .empty (fifo_empty),
        .level (fifo_level)
    );

    cpu_bus_sm u_bus_sm (
        .CLK90, .CCRESET_,
        .cfg, .start, .bgrant_, .rsp,
        .fifo_full, .fifo_empty, .fifo_rdata,
        .req, .arb, .busy, .finish,
        .fifo_push  (bus_push),
        .fifo_pop   (bus_pop),
        .fifo_wdata (bus_wdata)
    );

endmodule

/* sim/sdmac_asserts.sv */
// Concurrent checks on the DMA top level, attached with bind
// Address strobe under bus ownership, Wishbone ack framing, FIFO level bound
`include "sdmac_macros.svh"

module sdmac_asserts (
    input logic                    CLK90,
    input logic                    CCRESET_,
    input logic                    wb_stb,
    input logic                    wb_ack,
    input sdmac_pkg::cpu_req_t     req,
    input sdmac_pkg::bus_arb_t     arb,
    input logic [`SDMAC_FIFO_AW:0] fifo_level
);
    timeunit 1ns;
    timeprecision 100ps;

    // Bus cycles only while the bus is owned
    as_with_bgack: assert property (
        @(posedge CLK90) disable iff (!CCRESET_) !req.as_ |-> arb.bgack
    ) else $error("as_ low while bgack is not asserted");

    ack_with_stb: assert property (
        @(posedge CLK90) disable iff (!CCRESET_) wb_ack |-> wb_stb
    ) else $error("wb_ack high without wb_stb");

    level_in_range: assert property (
        @(posedge CLK90) disable iff (!CCRESET_) fifo_level <= `SDMAC_FIFO_DEPTH
    ) else $error("FIFO level above its depth");

endmodule

bind sdmac_top sdmac_asserts i_asserts (
    .CLK90, .CCRESET_, .wb_stb, .wb_ack, .req, .arb, .fifo_level
);

/* sim/sdmac_tb.sv */
// Testbench for the SCSI DMA controller
// Clock and reset, Wishbone driver, CPU bus memory model with LCG wait states,
// reference function, compare process and cycle timeout
`include "sdmac_macros.svh"

module sdmac_tb;
    timeunit 1ns;
    timeprecision 100ps;

    parameter logic [31:0] SEED = 32'h23009f40;
    // 33 words cross the CPU bus over all tests
    localparam int TIMEOUT_CYCLES = 200 * 33 + 1000;

    logic                     CLK90;
    logic                     CCRESET_;
    logic                     wb_cyc;
    logic                     wb_stb;
    logic                     wb_we;
    logic [`SDMAC_WB_AW-1:0]  wb_adr;
    logic [`SDMAC_DATA_W-1:0] wb_dat_w;
    logic [`SDMAC_DATA_W-1:0] wb_dat_r;
    logic                     wb_ack;
    logic                     bgrant_;
    sdmac_pkg::cpu_rsp_t      rsp;
    sdmac_pkg::cpu_req_t      req;
    sdmac_pkg::bus_arb_t      arb;

    // Big-endian memory in half-words keyed by address bits 31:1
    logic [15:0] mem16 [int unsigned];
    logic [31:0] lcg_state = SEED;
    int          bus_cycles = 0;
    int          errors = 0;
    int          queued = 0;
    int          compared = 0;
    logic [31:0] got_q [$];
    logic [31:0] exp_q [$];
    string       what_q [$];

    sdmac_top i_sdmac_top (
        .CLK90, .CCRESET_,
        .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w, .wb_dat_r, .wb_ack,
        .bgrant_, .rsp, .req, .arb
    );

    function logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic [15:0] half_pat(input logic [31:0] h);
        return h[15:0] ^ {h[7:0], h[15:8]} ^ h[31:16] ^ 16'h3c5a;
    endfunction

    // Word the host pushes for a given bus address
    function automatic logic [31:0] src_word(input logic [31:0] a);
        return a ^ {a[15:0], a[31:16]} ^ 32'hc3a5_5a3c;
    endfunction

    // Expected word idx of a transfer with the high half at the lower address
    function automatic logic [31:0] expected_word(input logic dir, input logic [31:0] base,
                                                  input int idx);
        logic [31:0] a;
        a = base + 32'(idx) * 4;
        if (dir) begin
            return {half_pat(a >> 1), half_pat((a >> 1) + 1)};
        end
        return src_word(a);
    endfunction

    task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("MISMATCH at time %0t: %s, got %h expected %h", $time, what, got, exp);
            $display("Result: FAILED");
            $fatal(1, "stopped at the first wrong value");
        end
    endtask

    task automatic expect_val(input logic [31:0] got, input logic [31:0] exp,
                              input string what);
        got_q.push_back(got);
        exp_q.push_back(exp);
        what_q.push_back(what);
        queued++;
    endtask

    task automatic wb_write(input logic [2:0] adr, input logic [31:0] data);
        @(negedge CLK90);
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = 1'b1;
        wb_adr   = adr;
        wb_dat_w = data;
        do @(negedge CLK90); while (!wb_ack);
        // Request stays up through the ack cycle
        @(negedge CLK90);
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic wb_read(input logic [2:0] adr, output logic [31:0] data);
        @(negedge CLK90);
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we  = 1'b0;
        wb_adr = adr;
        do @(negedge CLK90); while (!wb_ack);
        data = wb_dat_r;
        @(negedge CLK90);
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
    endtask

    task automatic push_words(input logic [31:0] base, input int n);
        for (int i = 0; i < n; i++) begin
            wb_write(`SDMAC_REG_DATA, expected_word(1'b0, base, i));
        end
    endtask

    task automatic start_transfer(input logic [31:0] base, input logic [31:0] count,
                                  input logic [31:0] ctrl);
        wb_write(`SDMAC_REG_ADDR, base);
        wb_write(`SDMAC_REG_COUNT, count);
        wb_write(`SDMAC_REG_CTRL, ctrl);
    endtask

    // Poll STATUS until done, then expect idle with an empty FIFO
    task automatic wait_done();
        logic [31:0] status;
        status = '0;
        while (!status[4]) begin
            wb_read(`SDMAC_REG_STATUS, status);
        end
        expect_val(status, 32'h10, "status at end of transfer");
    endtask

    task automatic check_written(input logic [31:0] base, input int n, input int cycles,
                                 input int exp_cycles);
        logic [31:0] h;
        for (int i = 0; i < n; i++) begin
            h = (base + 32'(i) * 4) >> 1;
            expect_val({mem16[h], mem16[h + 1]}, expected_word(1'b0, base, i),
                       $sformatf("memory word %0d from %h", i, base));
        end
        h = (base + 32'(n) * 4) >> 1;
        expect_val(32'(mem16.exists(h)), 32'h0, "no write past the last word");
        expect_val(32'(cycles), 32'(exp_cycles), "bus cycle count");
    endtask

    initial begin
        CLK90 = 1'b0;
        forever #4 CLK90 = ~CLK90;
    end

    // Arbiter grants the bus half a cycle after a request
    initial begin
        bgrant_ = 1'b1;
        forever begin
            @(negedge CLK90);
            bgrant_ = ~arb.breq;
        end
    end

    // Memory model where bit 15 of the address selects a 16-bit port on D31:16
    initial begin : cpu_bus_memory
        logic [31:0] r;
        logic [31:0] a;
        logic [31:0] h;
        int unsigned k;
        int          waits;
        rsp = '{dsack_: 2'b11, sterm_: 1'b1, rdata: '0};
        for (k = 32'h7ff0 >> 1; k < (32'h8010 >> 1); k++) begin
            mem16[k] = half_pat(k);
        end
        for (k = 32'ha000 >> 1; k < (32'ha010 >> 1); k++) begin
            mem16[k] = half_pat(k);
        end
        forever begin
            @(negedge CLK90);
            if (!req.as_) begin
                a = req.addr;
                h = a >> 1;
                // Both strobes fall together and siz16 marks the low half at addr+2
                expect_val(32'(req.ds_), 32'h0, "ds_ low with as_");
                expect_val(32'(req.siz16), 32'(a[1]), $sformatf("siz16 at %h", a));
                r     = lcg_next();
                waits = int'(r[17:16]);
                repeat (waits) @(negedge CLK90);
                if (req.rw) begin
                    rsp.rdata = a[15] ? {mem16[h], 16'hdead} : {mem16[h], mem16[h + 1]};
                end else begin
                    mem16[h] = req.wdata[31:16];
                    if (!a[15]) begin
                        mem16[h + 1] = req.wdata[15:0];
                    end
                end
                if (a[15]) begin
                    rsp.dsack_ = 2'b01;
                end else if (r[20]) begin
                    rsp.sterm_ = 1'b0;
                end else begin
                    rsp.dsack_ = 2'b00;
                end
                bus_cycles++;
                while (!req.as_) @(negedge CLK90);
                expect_val(32'(req.ds_), 32'h1, "ds_ high with as_");
                rsp.dsack_ = 2'b11;
                rsp.sterm_ = 1'b1;
            end
        end
    end

    always @(negedge CLK90) begin
        while (exp_q.size() != 0) begin
            check(got_q.pop_front(), exp_q.pop_front(), what_q.pop_front());
            compared++;
        end
    end

    initial begin : watchdog
        int cycles;
        cycles = 0;
        while (cycles <= TIMEOUT_CYCLES) begin
            @(posedge CLK90);
            cycles++;
        end
        $display("Timeout: the tests did not finish within %0d clock cycles", TIMEOUT_CYCLES);
        $display("Result: FAILED");
        $fatal(1, "run stopped by the cycle limit");
    end

    initial begin : stimulus
        logic [31:0] d;
        int          c0;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = '0;
        wb_dat_w = '0;
        CCRESET_ = 1'b0;
        repeat (3) @(negedge CLK90);
        CCRESET_ = 1'b1;

        // Idle state after reset
        expect_val(32'(arb.breq), 32'h0, "breq after reset");
        expect_val(32'(arb.bgack), 32'h0, "bgack after reset");
        expect_val(32'(req.as_), 32'h1, "as_ after reset");
        expect_val(32'(req.ds_), 32'h1, "ds_ after reset");
        wb_read(`SDMAC_REG_STATUS, d);
        expect_val(d, 32'h0, "status after reset");

        // Write direction to a 32-bit region
        c0 = bus_cycles;
        push_words(32'h1000, 8);
        start_transfer(32'h1000, 8, 32'h1);
        wait_done();
        check_written(32'h1000, 8, bus_cycles - c0, 8);

        // Same to a 16-bit region with two half cycles per word
        c0 = bus_cycles;
        push_words(32'h9000, 8);
        start_transfer(32'h9000, 8, 32'h1);
        wait_done();
        check_written(32'h9000, 8, bus_cycles - c0, 16);

        // Read direction across the 32-bit to 16-bit boundary
        start_transfer(32'h7ff0, 8, 32'h3);
        for (int i = 0; i < 8; i++) begin
            wb_read(`SDMAC_REG_DATA, d);
            expect_val(d, expected_word(1'b1, 32'h7ff0, i), $sformatf("read word %0d", i));
        end
        wait_done();

        // Flush with 5 of 8 words available
        c0 = bus_cycles;
        push_words(32'h2000, 5);
        start_transfer(32'h2000, 8, 32'h1);
        wb_write(`SDMAC_REG_CTRL, 32'h4);
        wait_done();
        check_written(32'h2000, 5, bus_cycles - c0, 5);

        // DATA read on an empty FIFO waits for the bus side
        c0 = bus_cycles;
        start_transfer(32'ha000, 4, 32'h3);
        wb_read(`SDMAC_REG_DATA, d);
        expect_val(32'(bus_cycles - c0 >= 2), 32'h1, "first DATA read held for bus word");
        expect_val(d, expected_word(1'b1, 32'ha000, 0), "held read word 0");
        for (int i = 1; i < 4; i++) begin
            wb_read(`SDMAC_REG_DATA, d);
            expect_val(d, expected_word(1'b1, 32'ha000, i), $sformatf("held read word %0d", i));
        end
        wait_done();

        wait (compared == queued);
        if (errors == 0) begin
            $display("Result: PASSED");
            $finish;
        end else begin
            $display("Result: FAILED");
            $fatal(1, "%0d checks failed", errors);
        end
    end

endmodule

/* sdmac_top.f */
+incdir+design
design/sdmac_pkg.sv
design/dma_regs.sv
design/dma_fifo.sv
design/cpu_bus_sm.sv
design/sdmac_top.sv
sim/sdmac_asserts.sv
sim/sdmac_tb.sv

/* Makefile */
# Verilator build and run of the SCSI DMA controller testbench

VERILATOR ?= verilator
TOP       ?= sdmac_tb
# LCG seed for the bus wait states, 587243328 is 32'h23009f40
SEED      ?= 587243328
OBJ_DIR   ?= obj_dir
FILELIST  ?= sdmac_top.f
VFLAGS    ?= --binary --timing --assert -j 0

SRCS := $(wildcard design/*.sv design/*.svh sim/*.sv)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -GSEED=$(SEED) \
		-Mdir $(OBJ_DIR) -f $(FILELIST)

# Exit status of the simulator is the test result
run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(OBJ_DIR)
